// ==== design/tileTimingPkg.sv ====
// Tile layer timing core constants
// Raster geometry, CPU register map and interrupt enable bit layout
// Shared by every block of the timing core and by its testbench
`default_nettype none

package tileTimingPkg;

    // Master clock
    localparam int PhaseCount = 4; // m24 cycles per pixel

    // Horizontal raster of 448 pixels per line
    localparam logic [8:0] HStart = 9'h040; // First count after line end
    localparam logic [8:0] HLast  = 9'h1FF; // Last pixel of the line

    // Vertical raster of 264 lines per frame
    localparam logic [8:0] VStart = 9'h0F8; // First line of the frame
    localparam logic [8:0] VLast  = 9'h1FF; // Last line before wrap

    // Raster interrupt sources
    localparam logic [8:0] VblankLine  = 9'h1F0; // Frame IRQ line
    localparam logic [8:0] NmiLineMask = 9'h01F; // NMI every 32 lines

    // CPU reset hold
    localparam int ResetFrames = 8; // Frames before CPU runs

    // CPU register window, AB[12:10] all set
    localparam logic [15:0] RegWindowBase = 16'h1C00;
    localparam logic [15:0] RegIrqEnAddr  = 16'h1D00; // Interrupt enables
    localparam logic [15:0] RegBankAddr   = 16'h1D80; // ROM bank select
    localparam logic [15:0] RegFlipAddr   = 16'h1E80; // Flip screen in bit 0

    // Bits of the interrupt enable register
    localparam int IrqEnNmiBit  = 0;
    localparam int IrqEnFirqBit = 1;
    localparam int IrqEnIrqBit  = 2;

endpackage

`default_nettype wire

// ==== design/clockPhaseGen.sv ====
// Master clock phase generator
// Splits m24 into the CPU clock, the E and Q quadrature phases
// and the 6 MHz pixel enable, all as levels on the m24 domain
`timescale 1ns/1ps
`default_nettype none

module clockPhaseGen
    import tileTimingPkg::*;
(
    input  logic m24,
    input  logic arstN,
    output logic m12,   // CPU clock, half of m24
    output logic pe,    // E phase
    output logic pq,    // Q phase
    output logic pixEn  // One pulse per pixel
);

    logic [$clog2(PhaseCount)-1:0] phase; // Position inside the pixel

    always_ff @(posedge m24 or negedge arstN) begin
        if (!arstN) begin
            phase <= '0;
            pq    <= 1'b0;
        end else begin
            phase <= phase + 1'b1; // Free running, wraps every pixel
            pq    <= pe;           // Q trails E by one m24 cycle
        end
    end

    assign m12   = phase[0];                          // Toggles each cycle
    assign pe    = phase[1];                          // High in phases 2 and 3
    assign pixEn = (int'(phase) == PhaseCount - 1);   // Last phase of the pixel

    // Pixel cadence seen by the raster counters
    assert property (@(posedge m24) disable iff (!arstN)
        pixEn |=> !pixEn [*PhaseCount-1] ##1 pixEn)
        else $error("pixEn not every %0d cycles", PhaseCount);

endmodule

`default_nettype wire

// ==== design/resetSequencer.sv ====
// Reset sequencer
// Synchronizes the board reset for the core and keeps the CPU
// in reset until eight frame interrupts have gone by
`timescale 1ns/1ps
`default_nettype none

module resetSequencer
    import tileTimingPkg::*;
(
    input  logic m24,
    input  logic arstN,
    input  logic irqTrig,  // One pulse per frame
    output logic coreRstN, // Reset of the timing core
    output logic cpuRstN   // Delayed CPU reset
);

    logic [1:0]                      syncQ;    // Release synchronizer
    logic [$clog2(ResetFrames)-1:0]  frameCnt; // Frames seen since release

    always_ff @(posedge m24 or negedge arstN) begin
        if (!arstN) begin
            syncQ <= '0;
        end else begin
            syncQ <= {syncQ[0], 1'b1};
        end
    end

    assign coreRstN = syncQ[1]; // Assert async, release after two edges

    always_ff @(posedge m24 or negedge coreRstN) begin
        if (!coreRstN) begin
            frameCnt <= '0;
            cpuRstN  <= 1'b0;
        end else if (irqTrig && !cpuRstN) begin
            frameCnt <= frameCnt + 1'b1;
            if (int'(frameCnt) == ResetFrames - 1) begin
                cpuRstN <= 1'b1; // Eighth frame, CPU may run
            end
        end
    end

    // CPU only goes back into reset through the board reset
    assert property (@(posedge m24) disable iff (!arstN) !$fell(cpuRstN))
        else $error("cpuRstN fell while arstN high");

endmodule

`default_nettype wire

// ==== design/rasterCounter.sv ====
// Raster counters
// Horizontal and vertical position counters stepped by the pixel
// enable, screen flip on the outputs and the frame, FIRQ and NMI
// raster triggers
`timescale 1ns/1ps
`default_nettype none

module rasterCounter
    import tileTimingPkg::*;
(
    input  logic       m24,
    input  logic       arstN,
    input  logic       pixEn,
    input  logic       flipScreen,
    output logic [8:0] pixH,     // Horizontal position for tile fetch
    output logic [8:0] rowV,     // Vertical position for tile fetch
    output logic       lineEnd,  // Last pixel of the line
    output logic       irqTrig,  // Entering the vblank line
    output logic       firqTrig, // Entering an even line
    output logic       nmiTrig   // Entering every 32nd line
);

    logic [8:0] hCnt;  // Horizontal count
    logic [8:0] vCnt;  // Vertical count
    logic [8:0] vNext; // Line count after this line ends

    assign lineEnd = pixEn && (hCnt == HLast);
    assign vNext   = (vCnt == VLast) ? VStart : vCnt + 9'd1;

    always_ff @(posedge m24 or negedge arstN) begin
        if (!arstN) begin
            hCnt <= HStart;
            vCnt <= VStart;
        end else if (pixEn) begin
            if (lineEnd) begin
                hCnt <= HStart; // Reload skips the blanked counts
                vCnt <= vNext;
            end else begin
                hCnt <= hCnt + 9'd1;
            end
        end
    end

    // Triggers line up with the new vertical count
    always_ff @(posedge m24 or negedge arstN) begin
        if (!arstN) begin
            irqTrig  <= 1'b0;
            firqTrig <= 1'b0;
            nmiTrig  <= 1'b0;
        end else begin
            irqTrig  <= lineEnd && (vNext == VblankLine);
            firqTrig <= lineEnd && !vNext[0];                         // Even rows
            nmiTrig  <= lineEnd && ((vNext & NmiLineMask) == 9'd0);   // Low bits clear
        end
    end

    // Flipped addressing, all bits inverted
    assign pixH = hCnt ^ {9{flipScreen}};
    assign rowV = vCnt ^ {9{flipScreen}};

    // Counter stays in the visible line range
    assert property (@(posedge m24) disable iff (!arstN)
        (hCnt >= HStart) && (hCnt <= HLast))
        else $error("ERR hCnt out of range %h", hCnt);

endmodule

`default_nettype wire

// ==== design/controlRegs.sv ====
// CPU control registers
// Wishbone classic slave in the 0x1C00 window with interrupt enables,
// screen flip and ROM bank, one cycle acknowledge
`timescale 1ns/1ps
`default_nettype none

module controlRegs
    import tileTimingPkg::*;
(
    input  logic        m24,
    input  logic        arstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [15:0] wbAdr,
    input  logic [7:0]  wbDatW,
    output logic        wbAck,
    output logic [7:0]  wbDatR,
    output logic [2:0]  irqEn,      // NMI, FIRQ, IRQ enables
    output logic        flipScreen,
    output logic [7:0]  romBank
);

    logic       req;                       // New request this cycle
    logic       inWindow;                  // AB[12:10] all set
    logic       selIrqEn, selFlip, selBank;
    logic [7:0] rdData;                    // Read mux

    assign req      = wbCyc && wbStb && !wbAck;
    assign inWindow = (wbAdr[12:10] == RegWindowBase[12:10]);
    assign selIrqEn = inWindow && (wbAdr[9:0] == RegIrqEnAddr[9:0]);
    assign selFlip  = inWindow && (wbAdr[9:0] == RegFlipAddr[9:0]);
    assign selBank  = inWindow && (wbAdr[9:0] == RegBankAddr[9:0]);

    always_comb begin
        rdData = 8'h00; // Unmapped reads as zero
        if (selIrqEn) rdData = {5'b0, irqEn};
        if (selFlip)  rdData = {7'b0, flipScreen};
        if (selBank)  rdData = romBank;
    end

    always_ff @(posedge m24 or negedge arstN) begin
        if (!arstN) begin
            wbAck      <= 1'b0;
            irqEn      <= '0;
            flipScreen <= 1'b0;
            romBank    <= '0;
        end else begin
            wbAck <= req; // Single cycle, master drops stb after it
            if (req && wbWe) begin
                if (selIrqEn) irqEn      <= wbDatW[2:0];
                if (selFlip)  flipScreen <= wbDatW[0];
                if (selBank)  romBank    <= wbDatW;
            end
        end
    end

    always_ff @(posedge m24) begin
        if (req) wbDatR <= rdData; // Valid with wbAck
    end

    // Back to back acknowledges would double a transfer
    assert property (@(posedge m24) disable iff (!arstN) wbAck |=> !wbAck)
        else $error("ERR wbAck high two cycles");

endmodule

`default_nettype wire

// ==== design/interruptFlags.sv ====
// Interrupt flags
// IRQ, FIRQ and NMI request latches, set by raster triggers and
// held released while their enable bit is clear
`timescale 1ns/1ps
`default_nettype none

module interruptFlags
    import tileTimingPkg::*;
(
    input  logic       m24,
    input  logic       arstN,
    input  logic [2:0] irqEn,    // Enable register bits
    input  logic       irqTrig,
    input  logic       firqTrig,
    input  logic       nmiTrig,
    output logic       irqN,
    output logic       firqN,
    output logic       nmiN
);

    logic [2:0] trig;  // Triggers in enable bit order
    logic [2:0] flagN; // Active low request flags

    assign trig[IrqEnNmiBit]  = nmiTrig;
    assign trig[IrqEnFirqBit] = firqTrig;
    assign trig[IrqEnIrqBit]  = irqTrig;

    always_ff @(posedge m24 or negedge arstN) begin
        if (!arstN) begin
            flagN <= '1;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (!irqEn[i]) begin
                    flagN[i] <= 1'b1; // Disable acknowledges the request
                end else if (trig[i]) begin
                    flagN[i] <= 1'b0;
                end
            end
        end
    end

    assign irqN  = flagN[IrqEnIrqBit];
    assign firqN = flagN[IrqEnFirqBit];
    assign nmiN  = flagN[IrqEnNmiBit];

    // A disabled source is released one cycle after the register write
    for (genvar i = 0; i < 3; i++) begin : gFlagChk
        assert property (@(posedge m24) disable iff (!arstN) !irqEn[i] |=> flagN[i])
            else $error("ERR flag %0d low with enable clear", i);
    end

endmodule

`default_nettype wire

// ==== design/tileTimingTop.sv ====
// Tile layer timing core
// Clock phases, reset sequencing, raster counters, CPU registers
// and raster interrupts of the tile video controller
`timescale 1ns/1ps
`default_nettype none

module tileTimingTop (
    input  logic        m24,
    input  logic        arstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [15:0] wbAdr,
    input  logic [7:0]  wbDatW,
    output logic        wbAck,
    output logic [7:0]  wbDatR,
    output logic        m12,
    output logic        pe,
    output logic        pq,
    output logic        cpuRstN,
    output logic [8:0]  pixH,
    output logic [8:0]  rowV,
    output logic [7:0]  romBank,
    output logic        irqN,
    output logic        firqN,
    output logic        nmiN
);

    logic       coreRstN;   // Synchronized core reset
    logic       pixEn;      // 6 MHz pixel enable
    logic       irqTrig;    // Vblank line reached
    logic       firqTrig;
    logic       nmiTrig;
    logic [2:0] irqEn;
    logic       flipScreen;

    clockPhaseGen i_phase (
        .m24(m24), .arstN(coreRstN),
        .m12(m12), .pe(pe), .pq(pq), .pixEn(pixEn)
    );

    resetSequencer i_reset (
        .m24(m24), .arstN(arstN), .irqTrig(irqTrig),
        .coreRstN(coreRstN), .cpuRstN(cpuRstN)
    );

    rasterCounter i_raster (
        .m24(m24), .arstN(coreRstN), .pixEn(pixEn), .flipScreen(flipScreen),
        .pixH(pixH), .rowV(rowV),
        .lineEnd(), // Only used inside the counters here
        .irqTrig(irqTrig), .firqTrig(firqTrig), .nmiTrig(nmiTrig)
    );

    controlRegs i_regs (
        .m24(m24), .arstN(coreRstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbAck(wbAck), .wbDatR(wbDatR),
        .irqEn(irqEn), .flipScreen(flipScreen), .romBank(romBank)
    );

    interruptFlags i_flags (
        .m24(m24), .arstN(coreRstN), .irqEn(irqEn),
        .irqTrig(irqTrig), .firqTrig(firqTrig), .nmiTrig(nmiTrig),
        .irqN(irqN), .firqN(firqN), .nmiN(nmiN)
    );

endmodule

`default_nettype wire

// ==== test/tbChecks.sv ====
// Timing core checker
// Tracks its own raster, phase, register and interrupt models from
// the raster and Wishbone rules and compares the DUT ports with them
`timescale 1ns/1ps
`default_nettype none

module tbChecks
    import tileTimingPkg::*;
(
    input  logic        m24,
    input  logic        arstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [15:0] wbAdr,
    input  logic [7:0]  wbDatW,
    input  logic        wbAck,
    input  logic [7:0]  wbDatR,
    input  logic        m12,
    input  logic        pe,
    input  logic        pq,
    input  logic        cpuRstN,
    input  logic [8:0]  pixH,
    input  logic [8:0]  rowV,
    input  logic [7:0]  romBank,
    input  logic        irqN,
    input  logic        firqN,
    input  logic        nmiN,
    output int          errors,  // Failed checks so far
    output int          frames   // Vblank lines reached by the model
);

    logic       synced;                 // Model locked to the pixel cadence
    logic [1:0] cnt;                    // Model phase inside the pixel
    logic [8:0] hM, vM, vNextM;         // Model raster counts
    logic [2:0] enM, pendM, flagM;      // Enables, triggers, active flags
    logic       flipM;
    logic [7:0] bankM, expRd;
    logic       req, inWin;

    assign req    = wbCyc && wbStb && !wbAck;
    assign inWin  = (wbAdr[12:10] == 3'b111);
    assign vNextM = (vM == VLast) ? VStart : vM + 9'd1;

    function automatic logic [7:0] readValue(input logic [15:0] adr, input logic [2:0] en,
                                             input logic flip, input logic [7:0] bank);
        if (adr[12:10] != 3'b111) return 8'h00; // Outside the window
        if (adr[9:0] == RegIrqEnAddr[9:0]) return {5'b0, en};
        if (adr[9:0] == RegFlipAddr[9:0]) return {7'b0, flip};
        if (adr[9:0] == RegBankAddr[9:0]) return bank;
        return 8'h00;
    endfunction

    always @(posedge m24 or negedge arstN) begin
        if (!arstN) begin
            synced <= 1'b0;
            cnt <= '0;
            hM <= HStart;
            vM <= VStart;
            frames <= 0;
            pendM <= '0;
            flagM <= '0;
            enM <= '0;
            flipM <= 1'b0;
            bankM <= '0;
            expRd <= '0;
        end else begin
            if (!synced && pixH != HStart) begin // First pixel step seen
                synced <= 1'b1;
                cnt <= 2'd1;
                hM <= HStart + 9'd1;
            end else if (synced) begin
                cnt <= cnt + 2'd1;
                pendM <= '0;
                if (cnt == 2'd3) begin // Pixel boundary
                    if (hM == HLast) begin
                        hM <= HStart;
                        vM <= vNextM;
                        if (vNextM == VblankLine) frames <= frames + 1;
                        pendM[IrqEnIrqBit]  <= (vNextM == VblankLine);
                        pendM[IrqEnFirqBit] <= !vNextM[0];
                        pendM[IrqEnNmiBit]  <= ((vNextM & NmiLineMask) == 9'd0);
                    end else begin
                        hM <= hM + 9'd1;
                    end
                end
            end
            for (int i = 0; i < 3; i++) begin
                if (!enM[i]) flagM[i] <= 1'b0;
                else if (pendM[i]) flagM[i] <= 1'b1;
            end
            if (req && wbWe && inWin) begin
                if (wbAdr[9:0] == RegIrqEnAddr[9:0]) enM <= wbDatW[2:0];
                if (wbAdr[9:0] == RegFlipAddr[9:0]) flipM <= wbDatW[0];
                if (wbAdr[9:0] == RegBankAddr[9:0]) bankM <= wbDatW;
            end
            if (req && !wbWe) expRd <= readValue(wbAdr, enM, flipM, bankM);
        end
    end

    initial errors = 0;

    // Count a failed check and print its line
    task automatic logFailure(input string msg);
        errors = errors + 1;
        $display("%s", msg);
    endtask

    // Phase and raster checks start once the model is locked
    assert property (@(posedge m24) disable iff (!arstN) synced |-> m12 != $past(m12))
        else logFailure($sformatf("ERR m12 got %h exp %h", m12, !m12));
    assert property (@(posedge m24) disable iff (!arstN) synced |-> pe == cnt[1])
        else logFailure($sformatf("ERR pe got %h exp %h", pe, cnt[1]));
    assert property (@(posedge m24) disable iff (!arstN) synced |-> pq == $past(pe))
        else logFailure($sformatf("ERR pq got %h exp %h", pq, $past(pe)));
    assert property (@(posedge m24) disable iff (!arstN) synced |-> pixH == (hM ^ {9{flipM}}))
        else logFailure($sformatf("ERR pixH got %h exp %h", pixH, hM ^ {9{flipM}}));
    assert property (@(posedge m24) disable iff (!arstN) synced |-> rowV == (vM ^ {9{flipM}}))
        else logFailure($sformatf("ERR rowV got %h exp %h", rowV, vM ^ {9{flipM}}));
    assert property (@(posedge m24) disable iff (!arstN)
        synced |-> cpuRstN == (frames >= ResetFrames && $past(frames) >= ResetFrames))
        else logFailure($sformatf("ERR cpuRstN got %h at frame %h", cpuRstN, frames));
    assert property (@(posedge m24) disable iff (!arstN) req |=> wbAck)
        else logFailure("Wishbone request not acknowledged next cycle");
    assert property (@(posedge m24) disable iff (!arstN) wbAck && !wbWe |-> wbDatR == expRd)
        else logFailure($sformatf("ERR wbDatR got %h exp %h", wbDatR, expRd));
    assert property (@(posedge m24) disable iff (!arstN) romBank == bankM)
        else logFailure($sformatf("ERR romBank got %h exp %h", romBank, bankM));
    assert property (@(posedge m24) disable iff (!arstN) irqN == !flagM[IrqEnIrqBit])
        else logFailure($sformatf("ERR irqN got %h exp %h", irqN, !flagM[IrqEnIrqBit]));
    assert property (@(posedge m24) disable iff (!arstN) firqN == !flagM[IrqEnFirqBit])
        else logFailure($sformatf("ERR firqN got %h exp %h", firqN, !flagM[IrqEnFirqBit]));
    assert property (@(posedge m24) disable iff (!arstN) nmiN == !flagM[IrqEnNmiBit])
        else logFailure($sformatf("ERR nmiN got %h exp %h", nmiN, !flagM[IrqEnNmiBit]));

endmodule

`default_nettype wire

// ==== test/tbTileTiming.sv ====
// Timing core testbench
// Register traffic, CPU reset hold, flip and interrupt enables
// over about eleven frames, checked by tbChecks
`timescale 1ns/1ps
`default_nettype none

module tbTileTiming;
    import tileTimingPkg::*;

    localparam int FrameCycles = (int'(HLast) - int'(HStart) + 1) *
                                 (int'(VLast) - int'(VStart) + 1) * PhaseCount;
    localparam int TimeoutCycles = 12 * FrameCycles + 10000; // Eleven frame run plus one spare

    logic m24 = 1'b0, arstN = 1'b0;
    logic wbCyc = 1'b0, wbStb = 1'b0, wbWe = 1'b0;
    logic [15:0] wbAdr = '0;
    logic [7:0] wbDatW = '0, wbDatR, romBank;
    logic wbAck, m12, pe, pq, cpuRstN, irqN, firqN, nmiN;
    logic [8:0] pixH, rowV;
    logic [15:0] lfsr = 16'd88;
    int errors, frames, cycles = 0, busErrors = 0, transfers = 0;

    always #5 m24 = !m24; // 10 ns period

    tileTimingTop i_dut (.*);
    tbChecks i_chk (.*);

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16 14 13 11
    endfunction

    task automatic randomBits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic busCycle(input logic we, input logic [15:0] adr, input logic [7:0] dat);
        int waitCnt;
        waitCnt = 0;
        @(negedge m24);
        {wbCyc, wbStb, wbWe, wbAdr, wbDatW} = {1'b1, 1'b1, we, adr, dat};
        do begin
            @(negedge m24);
            waitCnt++;
        end while (!wbAck && waitCnt < 16);
        if (!wbAck) begin
            busErrors++;
            $display("No acknowledge for access at %h", adr);
        end
        {wbCyc, wbStb} = 2'b00;
        transfers++;
    endtask

    task automatic waitFrames(input int n);
        while (frames < n) @(negedge m24);
    endtask

    initial begin
        logic [7:0] v;
        repeat (2) @(negedge m24);
        arstN = 1'b1;
        repeat (2) @(negedge m24); // Core reset releases two cycles later
        for (int k = 0; k < 4; k++) begin // Registers read back what was written
            randomBits(8, v);
            busCycle(1'b1, RegBankAddr, v);
            busCycle(1'b0, RegBankAddr, 8'h00);
            randomBits(8, v);
            busCycle(1'b1, RegIrqEnAddr, v);
            busCycle(1'b0, RegIrqEnAddr, 8'h00);
        end
        busCycle(1'b1, RegIrqEnAddr, 8'h00); // Interrupts off for the first frame
        busCycle(1'b1, RegFlipAddr, 8'hFE);
        busCycle(1'b0, RegFlipAddr, 8'h00);
        busCycle(1'b0, 16'h0000, 8'h00);
        busCycle(1'b0, 16'h1C04, 8'h00);
        busCycle(1'b0, 16'h1F00, 8'h00);
        waitFrames(2);
        busCycle(1'b1, RegIrqEnAddr, 8'h07);
        while (!cpuRstN) @(negedge m24);
        busCycle(1'b1, RegFlipAddr, 8'h01); // Flipped raster from here
        busCycle(1'b0, RegFlipAddr, 8'h00);
        waitFrames(10);
        busCycle(1'b1, RegIrqEnAddr, 8'h00); // Releases all flags
        repeat (4 * FrameCycles / 264) @(negedge m24);
        randomBits(3, v);
        busCycle(1'b1, RegIrqEnAddr, v);
        waitFrames(11);
        $display("errors=%0d busErrors=%0d transfers=%0d frames=%0d",
                 errors, busErrors, transfers, frames);
        if (errors == 0 && busErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(posedge m24) begin
        cycles++;
        if (cycles > TimeoutCycles) begin
            $display("Timeout after %0d cycles, run did not finish", cycles);
            $display("Test failures found");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/tileTimingPkg.sv
design/clockPhaseGen.sv
design/resetSequencer.sv
design/rasterCounter.sv
design/controlRegs.sv
design/interruptFlags.sv
design/tileTimingTop.sv
test/tbChecks.sv
test/tbTileTiming.sv

// ==== runSim.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTileTiming -f sources.f -o simTileTiming
./obj_dir/simTileTiming | tee sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
else
    exit 1
fi
